// ==== verilog.f ====
lf_pkg.sv
lf_ctl_if.sv
lf_ctl_sync.sv
lf_dco_integrator.sv
lf_dac_integrator.sv
lf_dac_sdm.sv
mdll_lf.sv
tb_clk_gen.sv
tb_mdll_lf.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the loop filter testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mdll_lf -f verilog.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_mdll_lf)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
exit 1

// ==== tb_mdll_lf.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mdll_lf;
	import lf_pkg::*;

	localparam int CYCLE_LIMIT = 3000;	// about twice the summed test lengths

	logic      clk_lf;
	logic      resetn_sync_clk_lf;
	logic      freeze_lf_dco_track, freeze_lf_dac_track, load, sel_dac_loop, en_hold;
	logic      bb_valid, bb_out_inc, en_sdm;
	dco_fine_t ld_value, dco_ctl_fine;
	dac_ctl_t  ld_value_dac, dac_ctl;
	gain_bb_t  gain_bb;
	gain_dac_t gain_bb_dac;

	int    dco_m;	// model dco track word, integer.fraction
	int    dac_m;	// model dac track word
	bit    dac_loop;	// model view of the loop select
	string test_name;
	int    cycle_cnt = 0;
	int    dac_sum;

	tb_clk_gen u_clk_gen (.clk_lf(clk_lf), .resetn_sync_clk_lf(resetn_sync_clk_lf));

	mdll_lf u_mdll_lf (.*);

	// ------------------------------------------------------------
	// helpers, model and compare
	// ------------------------------------------------------------
	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk_lf);
			#1;	// stay 1 ns past the edge
		end
	endtask

	task automatic check_dco(input string name, input dco_fine_t exp, input dco_fine_t act);
		if (act !== exp) begin
			$display("[FAIL] %s dco_ctl_fine expected %0d actual %0d", name, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1, "dco_ctl_fine mismatch");
		end
	endtask

	task automatic check_dac(input string name, input dac_ctl_t exp, input dac_ctl_t act);
		if (act !== exp) begin
			$display("[FAIL] %s dac_ctl expected %0d actual %0d", name, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1, "dac_ctl mismatch");
		end
	endtask

	// +/- 2**gain fraction lsbs, clip to zero or to max integer.0
	function automatic int sat_step(int word, int gain, bit inc, int n_int, int n_frac);
		int v;
		if (gain == 0) begin
			return word;	// gain 0, no step
		end
		v = inc ? word + (1 << gain) : word - (1 << gain);
		if (v < 0) begin
			v = 0;
		end else if (v >= (1 << (n_int + n_frac))) begin
			v = ((1 << n_int) - 1) << n_frac;
		end
		return v;
	endfunction

	task automatic check_outputs();
		check_dco(test_name, dco_fine_t'(dco_m >> N_DCO_TF), dco_ctl_fine);
		check_dac(test_name, dac_ctl_t'(dac_m >> N_DAC_TF), dac_ctl);
	endtask

	// one pd strobe, dco checked 2 cycles later and dac_ctl one after
	task automatic strobe_and_check(input bit inc);
		if (!freeze_lf_dco_track && !(dac_loop && en_hold))
			dco_m = sat_step(dco_m, gain_bb, inc, N_DCO_TI, N_DCO_TF);
		if (!freeze_lf_dac_track)
			dac_m = dac_loop ? sat_step(dac_m, gain_bb_dac, inc, N_DAC_TI, N_DAC_TF)
				: int'(ld_value_dac) << N_DAC_TF;	// parked in bb mode
		bb_valid   = 1'b1;
		bb_out_inc = inc;
		wait_cycles(1);
		bb_valid   = 1'b0;
		bb_out_inc = 1'b0;
		wait_cycles(1);
		check_dco(test_name, dco_fine_t'(dco_m >> N_DCO_TF), dco_ctl_fine);
		wait_cycles(1);
		check_dac(test_name, dac_ctl_t'(dac_m >> N_DAC_TF), dac_ctl);
	endtask

	task automatic load_and_check(input dco_fine_t v, input dac_ctl_t vd);
		ld_value     = v;
		ld_value_dac = vd;
		load         = 1'b1;
		wait_cycles(5);
		check_dco(test_name, v, dco_ctl_fine);
		check_dac(test_name, vd, dac_ctl);
		load = 1'b0;
		wait_cycles(5);
		dco_m = int'(v) << N_DCO_TF;
		dac_m = int'(vd) << N_DAC_TF;
	endtask

	task automatic set_dac_loop(input bit on);
		sel_dac_loop = on;
		wait_cycles(6);	// sync plus edge detect flop
		if (on && !freeze_lf_dco_track && (dco_m >> N_DCO_TF) != 0)
			dco_m -= 1 << N_DCO_TF;	// entry drops one integer code
		if (!on && !freeze_lf_dac_track)
			dac_m = int'(ld_value_dac) << N_DAC_TF;
		dac_loop = on;
		check_outputs();
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic test_reset_load();
		test_name = "test_reset_load";
		check_dco(test_name, '0, dco_ctl_fine);
		check_dac(test_name, '0, dac_ctl);
		load_and_check(8'ha5, 6'h2b);
		check_outputs();	// dac stays parked at ld_value_dac
	endtask

	task automatic test_bb_integrate();
		test_name = "test_bb_integrate";
		for (int g = 1; g <= 5; g++) begin
			gain_bb = gain_bb_t'(g);
			wait_cycles(5);
			repeat (40) begin
				wait_cycles($urandom_range(2, 0));	// random gap
				strobe_and_check($urandom_range(1, 0));
			end
		end
		gain_bb = '0;
		load_and_check(8'h5a, ld_value_dac);	// zero fraction, any step down shows
		repeat (5) strobe_and_check(1'b0);
		freeze_lf_dco_track = 1'b1;
		gain_bb = 3'd4;
		wait_cycles(5);
		repeat (5) strobe_and_check(1'b0);	// frozen, no move
		freeze_lf_dco_track = 1'b0;
		wait_cycles(5);
	endtask

	task automatic test_saturation();
		test_name = "test_saturation";
		gain_bb = 3'd7;	// two integer codes per step
		load_and_check(8'hff, 6'h3f);
		repeat (3) strobe_and_check(1'b1);
		check_dco(test_name, 8'hff, dco_ctl_fine);
		load_and_check(8'h00, 6'h00);
		repeat (3) strobe_and_check(1'b0);
		check_dco(test_name, 8'h00, dco_ctl_fine);
	endtask

	task automatic test_dac_mode();
		test_name   = "test_dac_mode";
		gain_bb     = 3'd2;
		gain_bb_dac = 3'd2;
		load_and_check(8'h00, 6'h20);
		set_dac_loop(1'b1);	// zero stays zero
		set_dac_loop(1'b0);
		load_and_check(8'h40, 6'h20);
		set_dac_loop(1'b1);
		check_dco(test_name, 8'h3f, dco_ctl_fine);
		repeat (8) strobe_and_check($urandom_range(1, 0));
		en_hold = 1'b1;
		gain_bb = 3'd6;	// one integer code per step if not held
		wait_cycles(5);
		repeat (8) strobe_and_check($urandom_range(1, 0));	// dco held
		set_dac_loop(1'b0);
		check_dac(test_name, 6'h20, dac_ctl);
		en_hold = 1'b0;
		wait_cycles(5);
	endtask

	task automatic test_sdm_dither();
		test_name    = "test_sdm_dither";
		ld_value_dac = 6'h15;
		gain_bb_dac  = 3'd1;
		en_hold      = 1'b1;
		wait_cycles(5);
		dac_m = int'(ld_value_dac) << N_DAC_TF;
		set_dac_loop(1'b1);
		repeat (3) strobe_and_check(1'b1);	// fraction 6/16
		freeze_lf_dac_track = 1'b1;
		wait_cycles(5);
		en_sdm = 1'b1;
		wait_cycles(2);
		dac_sum = 0;
		repeat (1 << N_DAC_TF) begin
			dac_sum += int'(dac_ctl);
			wait_cycles(1);
		end
		// window sum = 16*integer + fraction
		check_dac(test_name, dac_ctl_t'(dac_m >> N_DAC_TF), dac_ctl_t'(dac_sum >> N_DAC_TF));
		check_dac(test_name, dac_ctl_t'(dac_m % (1 << N_DAC_TF)),
			dac_ctl_t'(dac_sum % (1 << N_DAC_TF)));
		en_sdm = 1'b0;
		freeze_lf_dac_track = 1'b0;
		wait_cycles(5);
	endtask

	// ------------------------------------------------------------
	// sequence and timeout
	// ------------------------------------------------------------
	initial begin
		void'($urandom(32'he944));
		freeze_lf_dco_track = 1'b0;
		freeze_lf_dac_track = 1'b0;
		load         = 1'b0;
		ld_value     = '0;
		ld_value_dac = '0;
		sel_dac_loop = 1'b0;
		en_hold      = 1'b0;
		bb_valid     = 1'b0;
		bb_out_inc   = 1'b0;
		gain_bb      = '0;
		gain_bb_dac  = '0;
		en_sdm       = 1'b0;
		dac_loop     = 1'b0;
		@(posedge resetn_sync_clk_lf);	// released 1 ns after an edge
		test_reset_load();
		test_bb_integrate();
		test_saturation();
		test_dac_mode();
		test_sdm_dither();
		$display("ALL TESTS PASSED");
		$finish;
	end

	always @(posedge clk_lf) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout, tests still running after %0d cycles", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$fatal(1, "simulation timed out");
		end
	end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
	output logic clk_lf,
	output logic resetn_sync_clk_lf
);
	localparam int HALF_PERIOD = 4;	// 8 ns clock
	localparam int RST_CYCLES  = 3;

	initial begin
		clk_lf = 1'b0;
		forever #HALF_PERIOD clk_lf = ~clk_lf;
	end

	// reset low for three cycles, released just after an edge
	initial begin
		resetn_sync_clk_lf = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_lf);
		#1 resetn_sync_clk_lf = 1'b1;
	end

endmodule

`default_nettype wire

// ==== mdll_lf.sv ====
`timescale 1ns/10ps
`default_nettype none

module mdll_lf (
	input  logic              clk_lf,
	input  logic              resetn_sync_clk_lf,	// already synchronized
	input  logic              freeze_lf_dco_track,
	input  logic              freeze_lf_dac_track,
	input  logic              load,
	input  lf_pkg::dco_fine_t ld_value,
	input  lf_pkg::dac_ctl_t  ld_value_dac,
	input  logic              sel_dac_loop,	// 1 dac supply loop, 0 bb loop
	input  logic              en_hold,
	input  logic              bb_valid,	// pd strobe
	input  logic              bb_out_inc,	// 1 inc delay, 0 dec
	input  lf_pkg::gain_bb_t  gain_bb,
	input  lf_pkg::gain_dac_t gain_bb_dac,
	input  logic              en_sdm,
	output lf_pkg::dco_fine_t dco_ctl_fine,
	output lf_pkg::dac_ctl_t  dac_ctl
);
	import lf_pkg::*;

	dac_track_t dac_track;	// integrator to sdm

	// ------------------------------------------------------------
	// stage 1, sync and decision register
	// ------------------------------------------------------------
	lf_ctl_if u_ctl_if ();

	lf_ctl_sync u_ctl_sync (
		.clk_lf              (clk_lf),
		.resetn_sync_clk_lf  (resetn_sync_clk_lf),
		.load                (load),
		.freeze_lf_dco_track (freeze_lf_dco_track),
		.freeze_lf_dac_track (freeze_lf_dac_track),
		.sel_dac_loop        (sel_dac_loop),
		.en_hold             (en_hold),
		.gain_bb             (gain_bb),
		.gain_bb_dac         (gain_bb_dac),
		.bb_valid            (bb_valid),
		.bb_out_inc          (bb_out_inc),
		.ctl                 (u_ctl_if.ctl_src)
	);

	// ------------------------------------------------------------
	// stage 2, integrators
	// ------------------------------------------------------------
	lf_dco_integrator u_dco_integrator (
		.clk_lf             (clk_lf),
		.resetn_sync_clk_lf (resetn_sync_clk_lf),
		.ld_value           (ld_value),
		.ctl                (u_ctl_if.dco_dst),
		.dco_ctl_fine       (dco_ctl_fine)
	);

	lf_dac_integrator u_dac_integrator (
		.clk_lf             (clk_lf),
		.resetn_sync_clk_lf (resetn_sync_clk_lf),
		.ld_value_dac       (ld_value_dac),
		.ctl                (u_ctl_if.dac_dst),
		.dac_track          (dac_track)
	);

	// stage 3, dither onto the supply dac
	lf_dac_sdm u_dac_sdm (
		.clk_lf             (clk_lf),
		.resetn_sync_clk_lf (resetn_sync_clk_lf),
		.en_sdm             (en_sdm),	// direct, not synchronized
		.dac_track          (dac_track),
		.dac_ctl            (dac_ctl)
	);

endmodule

`default_nettype wire

// ==== lf_dac_sdm.sv ====
`timescale 1ns/10ps
`default_nettype none

module lf_dac_sdm (
	input  logic               clk_lf,
	input  logic               resetn_sync_clk_lf,
	input  logic               en_sdm,
	input  lf_pkg::dac_track_t dac_track,
	output lf_pkg::dac_ctl_t   dac_ctl
);
	import lf_pkg::*;

	logic [N_DAC_TF-1:0] acc_q;	// first-order error accumulator
	logic [N_DAC_TF:0]   acc_sum;	// msb is the carry
	logic                dither;

	// ------------------------------------------------------------
	// fraction accumulator, carry out is the dither bit
	// ------------------------------------------------------------
	assign acc_sum = {1'b0, acc_q} + {1'b0, dac_track[N_DAC_TF-1:0]};
	assign dither  = en_sdm & acc_sum[N_DAC_TF];

	always_ff @(posedge clk_lf or negedge resetn_sync_clk_lf) begin
		if (!resetn_sync_clk_lf) begin
			acc_q <= '0;
		end else if (en_sdm) begin
			acc_q <= acc_sum[N_DAC_TF-1:0];	// wraps, residue kept
		end
	end

	// integer part plus dither, no overflow since max word has zero fraction
	always_ff @(posedge clk_lf or negedge resetn_sync_clk_lf) begin
		if (!resetn_sync_clk_lf) begin
			dac_ctl <= '0;
		end else begin
			dac_ctl <= dac_track[N_DAC_TF +: N_DAC_TI] + dac_ctl_t'(dither);
		end
	end

	// sdm off means dac_ctl is the plain integer part one cycle later
	a_no_dither_when_off: assert property (@(posedge clk_lf)
		disable iff (!resetn_sync_clk_lf)
		!en_sdm |=> dac_ctl == $past(dac_track[N_DAC_TF +: N_DAC_TI]));

endmodule

`default_nettype wire

// ==== lf_dac_integrator.sv ====
`timescale 1ns/10ps
`default_nettype none

module lf_dac_integrator (
	input  logic               clk_lf,
	input  logic               resetn_sync_clk_lf,
	input  lf_pkg::dac_ctl_t   ld_value_dac,
	lf_ctl_if.dac_dst          ctl,
	output lf_pkg::dac_track_t dac_track
);
	import lf_pkg::*;

	dac_track_t                track_q;
	dac_track_t                track_nxt;
	dac_track_t                sum_clip;
	logic signed [N_DAC_T+1:0] mag;
	logic signed [N_DAC_T+1:0] step;
	logic signed [N_DAC_T+1:0] sum_raw;
	logic                      in_bb;	// bb loop active, dac parked

	// ------------------------------------------------------------
	// scaled decision and saturating add
	// ------------------------------------------------------------
	always_comb begin
		mag = (N_DAC_T+2)'(1) << ctl.gain_dac;
		if (!ctl.bb_valid || ctl.gain_dac == '0) begin
			step = '0;
		end else begin
			step = ctl.bb_inc ? mag : -mag;
		end
		sum_raw = $signed({2'b00, track_q}) + step;

		if (sum_raw[N_DAC_T+1]) begin
			sum_clip = '0;	// below zero
		end else if (sum_raw[N_DAC_T]) begin
			sum_clip = DAC_TRACK_MAX;	// zero fraction keeps sdm sum in range
		end else begin
			sum_clip = sum_raw[N_DAC_T-1:0];
		end
	end

	assign in_bb = (ctl.mode == MODE_BB) || (ctl.mode == MODE_DAC_EXIT);

	// ------------------------------------------------------------
	// update precedence
	// ------------------------------------------------------------
	always_comb begin
		if (ctl.freeze_dac) begin
			track_nxt = track_q;
		end else if (in_bb || ctl.load) begin
			track_nxt = {ld_value_dac, {N_DAC_TF{1'b0}}};	// park at load value
		end else begin
			track_nxt = sum_clip;	// enter and dac modes integrate
		end
	end

	always_ff @(posedge clk_lf or negedge resetn_sync_clk_lf) begin
		if (!resetn_sync_clk_lf) begin
			track_q <= '0;
		end else begin
			track_q <= track_nxt;
		end
	end

	assign dac_track = track_q;

	// in dac mode only a strobe or a load moves the word
	a_dac_needs_strobe: assert property (@(posedge clk_lf)
		disable iff (!resetn_sync_clk_lf)
		(ctl.mode == MODE_DAC) && !ctl.bb_valid && !ctl.load |=> $stable(track_q));

endmodule

`default_nettype wire

// ==== lf_dco_integrator.sv ====
`timescale 1ns/10ps
`default_nettype none

module lf_dco_integrator (
	input  logic              clk_lf,
	input  logic              resetn_sync_clk_lf,
	input  lf_pkg::dco_fine_t ld_value,
	lf_ctl_if.dco_dst         ctl,
	output lf_pkg::dco_fine_t dco_ctl_fine
);
	import lf_pkg::*;

	dco_track_t                track_q;	// integer.fraction
	dco_track_t                track_nxt;
	dco_track_t                sum_clip;	// track plus step, saturated
	logic signed [N_DCO_T+1:0] mag;	// 2**gain in fraction lsbs
	logic signed [N_DCO_T+1:0] step;
	logic signed [N_DCO_T+1:0] sum_raw;	// two guard bits

	// ------------------------------------------------------------
	// scaled decision and saturating add
	// ------------------------------------------------------------
	always_comb begin
		mag = (N_DCO_T+2)'(1) << ctl.gain_bb;
		if (!ctl.bb_valid || ctl.gain_bb == '0) begin
			step = '0;	// no strobe or gain 0
		end else begin
			step = ctl.bb_inc ? mag : -mag;
		end
		sum_raw = $signed({2'b00, track_q}) + step;

		if (sum_raw[N_DCO_T+1]) begin
			sum_clip = '0;	// underflow
		end else if (sum_raw[N_DCO_T]) begin
			sum_clip = DCO_TRACK_MAX;	// overflow
		end else begin
			sum_clip = sum_raw[N_DCO_T-1:0];
		end
	end

	// ------------------------------------------------------------
	// update precedence
	// ------------------------------------------------------------
	always_comb begin
		track_nxt = track_q;
		if (ctl.freeze_dco) begin
			track_nxt = track_q;	// freeze beats load
		end else if (ctl.load) begin
			track_nxt = {ld_value, {N_DCO_TF{1'b0}}};
		end else if (ctl.mode == MODE_DAC_ENTER) begin
			// hand over to dac loop one code lower
			track_nxt = sum_clip;
			if (sum_clip[N_DCO_TF +: N_DCO_TI] != '0) begin
				track_nxt[N_DCO_TF +: N_DCO_TI] = sum_clip[N_DCO_TF +: N_DCO_TI] - 1'b1;
			end
		end else if (ctl.mode == MODE_DAC && ctl.en_hold) begin
			track_nxt = track_q;	// dac loop owns the tracking
		end else begin
			track_nxt = sum_clip;
		end
	end

	always_ff @(posedge clk_lf or negedge resetn_sync_clk_lf) begin
		if (!resetn_sync_clk_lf) begin
			track_q <= '0;
		end else begin
			track_q <= track_nxt;
		end
	end

	assign dco_ctl_fine = track_q[N_DCO_TF +: N_DCO_TI];	// integer part only

	// synchronized freeze holds the word even with load high
	a_freeze_holds: assert property (@(posedge clk_lf)
		disable iff (!resetn_sync_clk_lf)
		ctl.freeze_dco |=> $stable(track_q));

endmodule

`default_nettype wire

// ==== lf_ctl_sync.sv ====
`timescale 1ns/10ps
`default_nettype none

module lf_ctl_sync (
	input  logic              clk_lf,
	input  logic              resetn_sync_clk_lf,
	input  logic              load,
	input  logic              freeze_lf_dco_track,
	input  logic              freeze_lf_dac_track,
	input  logic              sel_dac_loop,
	input  logic              en_hold,
	input  lf_pkg::gain_bb_t  gain_bb,
	input  lf_pkg::gain_dac_t gain_bb_dac,
	input  logic              bb_valid,
	input  logic              bb_out_inc,
	lf_ctl_if.ctl_src         ctl
);
	import lf_pkg::*;

	// ------------------------------------------------------------
	// control synchronizers
	// ------------------------------------------------------------
	logic [N_CTL_SYNC-1:0] ctl_raw;	// async side, packed
	logic [SYNC_DEPTH-1:0][N_CTL_SYNC-1:0] sync_q;	// [0] first flop
	logic                  sel_sync;
	logic                  sel_dly;	// one more flop for edge detect
	lf_mode_e              mode_d;

	assign ctl_raw = {load, freeze_lf_dco_track, freeze_lf_dac_track,
		sel_dac_loop, en_hold, gain_bb, gain_bb_dac};

	// all bits ride the same chain
	always_ff @(posedge clk_lf or negedge resetn_sync_clk_lf) begin
		if (!resetn_sync_clk_lf) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[SYNC_DEPTH-2:0], ctl_raw};
		end
	end

	// unpack last stage
	assign {ctl.load, ctl.freeze_dco, ctl.freeze_dac, sel_sync,
		ctl.en_hold, ctl.gain_bb, ctl.gain_dac} = sync_q[SYNC_DEPTH-1];

	// ------------------------------------------------------------
	// loop select edge decode
	// ------------------------------------------------------------
	always_ff @(posedge clk_lf or negedge resetn_sync_clk_lf) begin
		if (!resetn_sync_clk_lf) begin
			sel_dly <= 1'b0;
		end else begin
			sel_dly <= sel_sync;
		end
	end

	always_comb begin
		case ({sel_sync, sel_dly})
			2'b10:   mode_d = MODE_DAC_ENTER;	// rise
			2'b11:   mode_d = MODE_DAC;
			2'b01:   mode_d = MODE_DAC_EXIT;	// fall
			default: mode_d = MODE_BB;
		endcase
	end

	assign ctl.mode = mode_d;

	// ------------------------------------------------------------
	// pd decision, same clock domain so one flop only
	// ------------------------------------------------------------
	always_ff @(posedge clk_lf or negedge resetn_sync_clk_lf) begin
		if (!resetn_sync_clk_lf) begin
			ctl.bb_valid <= 1'b0;
		end else begin
			ctl.bb_valid <= bb_valid;
		end
	end

	always_ff @(posedge clk_lf) begin
		ctl.bb_inc <= bb_out_inc;	// qualified by bb_valid
	end

	// back-to-back strobes downstream only when the pd sent two
	a_strobe_no_stretch: assert property (@(posedge clk_lf)
		disable iff (!resetn_sync_clk_lf)
		ctl.bb_valid && $past(ctl.bb_valid) |-> $past(bb_valid, 1) && $past(bb_valid, 2));

endmodule

`default_nettype wire

// ==== lf_ctl_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface lf_ctl_if;
	import lf_pkg::*;

	// synchronized quasi-static controls
	logic      load;
	logic      freeze_dco;
	logic      freeze_dac;
	gain_bb_t  gain_bb;
	gain_dac_t gain_dac;
	lf_mode_e  mode;	// decoded from delayed loop select
	logic      en_hold;

	// registered pd decision
	logic      bb_valid;	// one cycle per decision
	logic      bb_inc;	// 1 inc, 0 dec

	// sync stage drives everything
	modport ctl_src (
		output load, freeze_dco, freeze_dac, gain_bb, gain_dac,
		output mode, en_hold, bb_valid, bb_inc
	);

	// dco tracking integrator
	modport dco_dst (
		input load, freeze_dco, gain_bb, mode, en_hold,
		input bb_valid, bb_inc
	);

	// supply-dac tracking integrator, no hold here
	modport dac_dst (
		input load, freeze_dac, gain_dac, mode,
		input bb_valid, bb_inc
	);

endinterface

`default_nettype wire

// ==== lf_pkg.sv ====
`default_nettype none

package lf_pkg;

	// ------------------------------------------------------------
	// word widths
	// ------------------------------------------------------------
	localparam int N_DCO_TI  = 8;	// dco track integer bits
	localparam int N_DCO_TF  = 6;	// dco track fraction bits
	localparam int N_DCO_T   = N_DCO_TI + N_DCO_TF;

	localparam int N_DAC_TI  = 6;	// dac track integer bits
	localparam int N_DAC_TF  = 4;	// dac track fraction bits, also sdm acc width
	localparam int N_DAC_T   = N_DAC_TI + N_DAC_TF;

	localparam int N_BB_GB   = 3;	// bb loop gain exponent
	localparam int N_BB_GDAC = 3;	// dac loop gain exponent

	localparam int SYNC_DEPTH = 2;	// flops per control synchronizer
	// load, two freezes, loop select, hold, both gains
	localparam int N_CTL_SYNC = 5 + N_BB_GB + N_BB_GDAC;

	// ------------------------------------------------------------
	// word types
	// ------------------------------------------------------------
	typedef logic [N_DCO_T-1:0]   dco_track_t;	// integer.fraction
	typedef logic [N_DAC_T-1:0]   dac_track_t;
	typedef logic [N_DCO_TI-1:0]  dco_fine_t;	// dco fine control
	typedef logic [N_DAC_TI-1:0]  dac_ctl_t;	// supply dac control
	typedef logic [N_BB_GB-1:0]   gain_bb_t;
	typedef logic [N_BB_GDAC-1:0] gain_dac_t;

	// saturation ceiling, max integer with zero fraction
	localparam dco_track_t DCO_TRACK_MAX = {{N_DCO_TI{1'b1}}, {N_DCO_TF{1'b0}}};
	localparam dac_track_t DAC_TRACK_MAX = {{N_DAC_TI{1'b1}}, {N_DAC_TF{1'b0}}};

	// loop mode, encoded as {sel_sync, sel_dly}
	typedef enum logic [1:0] {
		MODE_BB        = 2'b00,	// select low
		MODE_DAC_EXIT  = 2'b01,	// falling edge, one cycle
		MODE_DAC_ENTER = 2'b10,	// rising edge, one cycle
		MODE_DAC       = 2'b11	// select high
	} lf_mode_e;

endpackage

`default_nettype wire
